/* logic/csr_pkg.sv */
package csr_pkg;

    localparam int csr_num_w  = 14;
    localparam int csr_data_w = 32;

    // CSR numbers.
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h040;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    // Field positions.
    localparam int crmd_plv_lo       = 0;
    localparam int crmd_plv_hi       = 1;
    localparam int crmd_ie_lo        = 2;
    localparam int crmd_ie_hi        = 2;
    localparam int crmd_da_lo        = 3;
    localparam int crmd_da_hi        = 3;
    localparam int crmd_pg_lo        = 4;
    localparam int crmd_pg_hi        = 4;
    localparam int crmd_datf_lo      = 5;
    localparam int crmd_datf_hi      = 6;
    localparam int crmd_datm_lo      = 7;
    localparam int crmd_datm_hi      = 8;
    localparam int prmd_pplv_lo      = 0;
    localparam int prmd_pplv_hi      = 1;
    localparam int prmd_pie_lo       = 2;
    localparam int prmd_pie_hi       = 2;
    localparam int ecfg_lie_lo       = 0;
    localparam int ecfg_lie_hi       = 12;
    localparam int estat_is_lo       = 0;
    localparam int estat_is_hi       = 12;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_ecode_hi    = 21;
    localparam int estat_esubcode_lo = 22;
    localparam int estat_esubcode_hi = 30;
    localparam int eentry_va_lo      = 6;
    localparam int eentry_va_hi      = 31;
    localparam int tcfg_en_lo        = 0;
    localparam int tcfg_en_hi        = 0;
    localparam int tcfg_periodic_lo  = 1;
    localparam int tcfg_periodic_hi  = 1;
    localparam int tcfg_initval_lo   = 2;
    localparam int tcfg_initval_hi   = 31;
    localparam int ticlr_clr_lo      = 0;
    localparam int ticlr_clr_hi      = 0;

    // Bit 10 of LIE is reserved.
    localparam logic [ecfg_lie_hi-ecfg_lie_lo:0] ecfg_lie_mask = 13'h1bff;

    localparam logic [5:0] ecode_ade     = 6'h08;
    localparam logic [5:0] ecode_ale     = 6'h09;
    localparam logic [8:0] esubcode_adef = 9'h000;

    typedef union packed {
        logic [csr_data_w-1:0] raw;
        struct packed {
            logic [tcfg_initval_hi-tcfg_initval_lo:0] initval;
            logic                                     periodic;
            logic                                     en;
        } f;
    } tcfg_word_u;

    function automatic logic [csr_data_w-1:0] csr_merge(
        input logic [csr_data_w-1:0] old_value,
        input logic [csr_data_w-1:0] wvalue,
        input logic [csr_data_w-1:0] wmask
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

/* logic/csr_priv_state.sv */
module csr_priv_state (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wmask,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wvalue,
    input  logic                           wb_ex,
    input  logic                           ertn_flush,
    input  logic [csr_pkg::csr_data_w-1:0] wb_pc,
    input  logic [5:0]                     wb_ecode,
    input  logic [8:0]                     wb_esubcode,
    input  logic [csr_pkg::csr_data_w-1:0] wb_vaddr,
    output logic                           crmd_ie,
    output logic [csr_pkg::csr_data_w-1:0] ex_entry,
    output logic [csr_pkg::csr_data_w-1:0] ertn_entry,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata
);
    import csr_pkg::*;

    logic [1:0]                         crmd_plv;
    logic                               crmd_da;
    logic                               crmd_pg;
    logic [1:0]                         crmd_dat;
    logic [1:0]                         prmd_pplv;
    logic                               prmd_pie;
    logic [csr_data_w-1:0]              era;
    logic [csr_data_w-1:0]              badv;
    logic [eentry_va_hi-eentry_va_lo:0] eentry_va;
    logic [5:0]                         ecode_q;
    logic [8:0]                         esubcode_q;
    logic [csr_data_w-1:0]              crmd_word;
    logic [csr_data_w-1:0]              prmd_word;
    logic [csr_data_w-1:0]              estat_word;
    logic [csr_data_w-1:0]              eentry_word;
    logic [csr_data_w-1:0]              crmd_next;
    logic [csr_data_w-1:0]              prmd_next;
    logic [csr_data_w-1:0]              era_next;
    logic [csr_data_w-1:0]              eentry_next;
    logic                               addr_err;

    // Direct address translation modes follow PG.
    assign crmd_dat = crmd_pg ? 2'b01 : 2'b00;

    always_comb begin
        crmd_word = '0;
        crmd_word[crmd_plv_hi:crmd_plv_lo]   = crmd_plv;
        crmd_word[crmd_ie_hi:crmd_ie_lo]     = crmd_ie;
        crmd_word[crmd_da_hi:crmd_da_lo]     = crmd_da;
        crmd_word[crmd_pg_hi:crmd_pg_lo]     = crmd_pg;
        crmd_word[crmd_datf_hi:crmd_datf_lo] = crmd_dat;
        crmd_word[crmd_datm_hi:crmd_datm_lo] = crmd_dat;
        prmd_word = '0;
        prmd_word[prmd_pplv_hi:prmd_pplv_lo] = prmd_pplv;
        prmd_word[prmd_pie_hi:prmd_pie_lo]   = prmd_pie;
        estat_word = '0;
        estat_word[estat_ecode_hi:estat_ecode_lo]       = ecode_q;
        estat_word[estat_esubcode_hi:estat_esubcode_lo] = esubcode_q;
        eentry_word = '0;
        eentry_word[eentry_va_hi:eentry_va_lo] = eentry_va;
    end

    assign crmd_next   = csr_merge(crmd_word, csr_wvalue, csr_wmask);
    assign prmd_next   = csr_merge(prmd_word, csr_wvalue, csr_wmask);
    assign era_next    = csr_merge(era, csr_wvalue, csr_wmask);
    assign eentry_next = csr_merge(eentry_word, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b0;
            crmd_pg  <= 1'b1;
        end else if (wb_ex) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == csr_crmd) begin
            crmd_plv <= crmd_next[crmd_plv_hi:crmd_plv_lo];
            crmd_ie  <= crmd_next[crmd_ie_hi:crmd_ie_lo];
            crmd_da  <= crmd_next[crmd_da_hi:crmd_da_lo];
            crmd_pg  <= crmd_next[crmd_pg_hi:crmd_pg_lo];
        end
    end

    // Exception entry saves the old privilege state and the faulting pc.
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv  <= crmd_plv;
            prmd_pie   <= crmd_ie;
            era        <= wb_pc;
            ecode_q    <= wb_ecode;
            esubcode_q <= wb_esubcode;
        end else begin
            if (csr_we && csr_num == csr_prmd) begin
                prmd_pplv <= prmd_next[prmd_pplv_hi:prmd_pplv_lo];
                prmd_pie  <= prmd_next[prmd_pie_hi:prmd_pie_lo];
            end
            if (csr_we && csr_num == csr_era)
                era <= era_next;
        end
    end

    assign addr_err = (wb_ecode == ecode_ade) || (wb_ecode == ecode_ale);

    // A fetch fault reports the pc itself.
    always_ff @(posedge clk) begin
        if (wb_ex && addr_err)
            badv <= (wb_ecode == ecode_ade && wb_esubcode == esubcode_adef) ? wb_pc : wb_vaddr;
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == csr_eentry)
            eentry_va <= eentry_next[eentry_va_hi:eentry_va_lo];
    end

    always_comb begin
        case (csr_num)
            csr_crmd:   csr_rdata = crmd_word;
            csr_prmd:   csr_rdata = prmd_word;
            csr_estat:  csr_rdata = estat_word;
            csr_era:    csr_rdata = era;
            csr_badv:   csr_rdata = badv;
            csr_eentry: csr_rdata = eentry_word;
            default:    csr_rdata = '0;
        endcase
    end

    assign ex_entry   = eentry_word;
    assign ertn_entry = era;

    // The pipeline retires an exception and an ERTN in different cycles.
    assert property (@(posedge clk) disable iff (reset) !(wb_ex && ertn_flush));

endmodule

/* logic/csr_int_ctrl.sv */
module csr_int_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wmask,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wvalue,
    input  logic [7:0]                     hw_int_in,
    input  logic                           ipi_int_in,
    input  logic                           timer_int,
    input  logic                           crmd_ie,
    output logic                           has_int,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata
);
    import csr_pkg::*;

    logic [ecfg_lie_hi-ecfg_lie_lo:0] lie;
    logic [estat_is_hi-estat_is_lo:0] is_bits;
    logic [1:0]                       is_sw;
    logic [7:0]                       is_hw;
    logic                             is_ipi;
    logic [csr_data_w-1:0]            ecfg_word;
    logic [csr_data_w-1:0]            estat_word;
    logic [csr_data_w-1:0]            ecfg_next;
    logic [csr_data_w-1:0]            estat_next;

    // Bit 10 is reserved, bit 11 is the timer.
    assign is_bits = {is_ipi, timer_int, 1'b0, is_hw, is_sw};

    always_comb begin
        ecfg_word = '0;
        ecfg_word[ecfg_lie_hi:ecfg_lie_lo] = lie;
        estat_word = '0;
        estat_word[estat_is_hi:estat_is_lo] = is_bits;
    end

    assign ecfg_next  = csr_merge(ecfg_word, csr_wvalue, csr_wmask);
    assign estat_next = csr_merge(estat_word, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            lie   <= '0;
            is_sw <= 2'b00;
        end else begin
            if (csr_we && csr_num == csr_ecfg)
                lie <= ecfg_next[ecfg_lie_hi:ecfg_lie_lo] & ecfg_lie_mask;
            if (csr_we && csr_num == csr_estat)
                is_sw <= estat_next[estat_is_lo+1:estat_is_lo];
        end
    end

    // External lines are sampled once.
    always_ff @(posedge clk) begin
        is_hw  <= hw_int_in;
        is_ipi <= ipi_int_in;
    end

    assign has_int = ((is_bits & lie) != '0) && crmd_ie;

    always_comb begin
        case (csr_num)
            csr_ecfg:  csr_rdata = ecfg_word;
            csr_estat: csr_rdata = estat_word;
            default:   csr_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) has_int |-> crmd_ie);

endmodule

/* logic/csr_timer.sv */
module csr_timer #(
    parameter logic [31:0] CORE_ID = 32'h0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wmask,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wvalue,
    output logic                           timer_int,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] tid;
    tcfg_word_u            tcfg_q;
    tcfg_word_u            tcfg_next;
    logic [csr_data_w-1:0] cnt;
    logic                  tcfg_wr;
    logic                  ticlr_wr;
    logic                  cnt_zero;

    assign tcfg_wr        = csr_we && csr_num == csr_tcfg;
    assign tcfg_next.raw  = csr_merge(tcfg_q.raw, csr_wvalue, csr_wmask);
    assign cnt_zero       = (cnt == '0);
    assign ticlr_wr       = csr_we && csr_num == csr_ticlr
                         && csr_wmask[ticlr_clr_hi:ticlr_clr_lo] == 1'b1
                         && csr_wvalue[ticlr_clr_hi:ticlr_clr_lo] == 1'b1;

    always_ff @(posedge clk) begin
        if (reset)
            tid <= CORE_ID;
        else if (csr_we && csr_num == csr_tid)
            tid <= csr_merge(tid, csr_wvalue, csr_wmask);
    end

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_q.f.en <= 1'b0;
        else if (tcfg_wr)
            tcfg_q <= tcfg_next;
    end

    // All ones marks a stopped one-shot timer.
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (tcfg_wr && tcfg_next.f.en) begin
            cnt <= {tcfg_next.f.initval, {tcfg_initval_lo{1'b0}}};
        end else if (tcfg_q.f.en && cnt != '1) begin
            if (cnt_zero && tcfg_q.f.periodic)
                cnt <= {tcfg_q.f.initval, {tcfg_initval_lo{1'b0}}};
            else
                cnt <= cnt - 1'b1;
        end
    end

    // Expiry wins over a clear in the same cycle.
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (cnt_zero)
            timer_int <= 1'b1;
        else if (ticlr_wr)
            timer_int <= 1'b0;
    end

    always_comb begin
        case (csr_num)
            csr_tid:   csr_rdata = tid;
            csr_tcfg:  csr_rdata = tcfg_q.raw;
            csr_tval:  csr_rdata = cnt;
            csr_ticlr: csr_rdata = '0;
            default:   csr_rdata = '0;
        endcase
    end

    // A disabled timer holds its count until TCFG is written.
    assert property (@(posedge clk) disable iff (reset)
        (!tcfg_q.f.en && !tcfg_wr) |=> $stable(cnt));

endmodule

/* logic/csr_save_regs.sv */
module csr_save_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                           clk,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wmask,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wvalue,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] save_q [SAVE_COUNT];

    always_ff @(posedge clk) begin
        for (int k = 0; k < SAVE_COUNT; k++) begin
            if (csr_we && csr_num == csr_save0 + csr_num_w'(k))
                save_q[k] <= csr_merge(save_q[k], csr_wvalue, csr_wmask);
        end
    end

    always_comb begin
        csr_rdata = '0;
        for (int k = 0; k < SAVE_COUNT; k++) begin
            if (csr_num == csr_save0 + csr_num_w'(k))
                csr_rdata = save_q[k];
        end
    end

endmodule

/* logic/csr_top.sv */
module csr_top #(
    parameter logic [31:0] CORE_ID    = 32'h0,
    parameter int          SAVE_COUNT = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wmask,
    input  logic [csr_pkg::csr_data_w-1:0] csr_wvalue,
    input  logic                           wb_ex,
    input  logic                           ertn_flush,
    input  logic [csr_pkg::csr_data_w-1:0] wb_pc,
    input  logic [5:0]                     wb_ecode,
    input  logic [8:0]                     wb_esubcode,
    input  logic [csr_pkg::csr_data_w-1:0] wb_vaddr,
    input  logic [7:0]                     hw_int_in,
    input  logic                           ipi_int_in,
    output logic [csr_pkg::csr_data_w-1:0] csr_rvalue,
    output logic                           has_int,
    output logic [csr_pkg::csr_data_w-1:0] ex_entry,
    output logic [csr_pkg::csr_data_w-1:0] ertn_entry
);
    import csr_pkg::*;

    logic                  crmd_ie;
    logic                  timer_int;
    logic [csr_data_w-1:0] priv_rdata;
    logic [csr_data_w-1:0] int_rdata;
    logic [csr_data_w-1:0] timer_rdata;
    logic [csr_data_w-1:0] save_rdata;

    csr_priv_state u_priv_state (
        .clk(clk), .reset(reset),
        .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_pc(wb_pc),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_vaddr(wb_vaddr),
        .crmd_ie(crmd_ie), .ex_entry(ex_entry), .ertn_entry(ertn_entry),
        .csr_rdata(priv_rdata)
    );

    csr_int_ctrl u_int_ctrl (
        .clk(clk), .reset(reset),
        .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .hw_int_in(hw_int_in), .ipi_int_in(ipi_int_in),
        .timer_int(timer_int), .crmd_ie(crmd_ie),
        .has_int(has_int), .csr_rdata(int_rdata)
    );

    csr_timer #(.CORE_ID(CORE_ID)) u_timer (
        .clk(clk), .reset(reset),
        .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .timer_int(timer_int), .csr_rdata(timer_rdata)
    );

    csr_save_regs #(.SAVE_COUNT(SAVE_COUNT)) u_save_regs (
        .clk(clk),
        .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .csr_rdata(save_rdata)
    );

    // Each block drives zero outside its own CSR numbers.
    assign csr_rvalue = priv_rdata | int_rdata | timer_rdata | save_rdata;

endmodule

/* testbench/csr_ref_model.svh */
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expected CSR state, stepped once per rising edge from the inputs of that cycle.
logic [1:0]  m_plv;
logic        m_ie;
logic        m_da;
logic        m_pg;
logic [1:0]  m_pplv;
logic        m_pie;
logic [31:0] m_era;
logic [31:0] m_eentry;
logic [31:0] m_badv;
logic [5:0]  m_ecode;
logic [8:0]  m_esubcode;
logic [12:0] m_lie;
logic [1:0]  m_is_sw;
logic [7:0]  m_is_hw;
logic        m_is_ipi;
logic [31:0] m_tid;
logic [31:0] m_tcfg;
logic [31:0] m_cnt;
logic        m_timer_int;
logic [31:0] m_save [4];

function automatic logic [31:0] apply_mask(input logic [31:0] old_value,
                                           input logic [31:0] value,
                                           input logic [31:0] mask);
    return (old_value & ~mask) | (value & mask);
endfunction

function automatic logic [12:0] is_value();
    // Bit 10 is reserved.
    return {m_is_ipi, m_timer_int, 1'b0, m_is_hw, m_is_sw};
endfunction

function automatic logic expected_has_int();
    return ((is_value() & m_lie) != 13'h0) && m_ie;
endfunction

function automatic logic [31:0] expected_read(input logic [13:0] num);
    logic [1:0] dat;
    dat = m_pg ? 2'b01 : 2'b00;
    case (num)
        csr_crmd:   return {23'h0, dat, dat, m_pg, m_da, m_ie, m_plv};
        csr_prmd:   return {29'h0, m_pie, m_pplv};
        csr_ecfg:   return {19'h0, m_lie};
        csr_estat:  return {1'b0, m_esubcode, m_ecode, 3'h0, is_value()};
        csr_era:    return m_era;
        csr_badv:   return m_badv;
        csr_eentry: return m_eentry;
        csr_tid:    return m_tid;
        csr_tcfg:   return m_tcfg;
        csr_tval:   return m_cnt;
        default: begin
            if (num >= csr_save0 && num <= csr_save0 + 14'd3)
                return m_save[num[1:0]];
            return 32'h0;
        end
    endcase
endfunction

task automatic model_update();
    logic [31:0] nxt;
    logic [31:0] tcfg_nxt;
    logic [1:0]  old_plv;
    logic        old_ie;
    logic        tcfg_wr;
    logic        ticlr_hit;
    old_plv = m_plv;
    old_ie = m_ie;
    // Merged value of whichever register is addressed.
    nxt = apply_mask(expected_read(csr_num), csr_wvalue, csr_wmask);
    tcfg_wr = csr_we && csr_num == csr_tcfg;
    tcfg_nxt = apply_mask(m_tcfg, csr_wvalue, csr_wmask);
    ticlr_hit = csr_we && csr_num == csr_ticlr && csr_wmask[0] && csr_wvalue[0];
    m_is_hw = hw_int_in;
    m_is_ipi = ipi_int_in;
    if (reset) begin
        m_plv = 2'b00;
        m_ie = 1'b0;
        m_da = 1'b0;
        m_pg = 1'b1;
        m_lie = 13'h0;
        m_is_sw = 2'b00;
        m_tid = core_id;
        m_tcfg[0] = 1'b0;
        m_cnt = 32'hffff_ffff;
        m_timer_int = 1'b0;
    end else begin
        // An exception wins over ERTN and over writes to CRMD, PRMD and ERA.
        if (wb_ex) begin
            m_plv = 2'b00;
            m_ie = 1'b0;
            m_pplv = old_plv;
            m_pie = old_ie;
            m_era = wb_pc;
            m_ecode = wb_ecode;
            m_esubcode = wb_esubcode;
            if (wb_ecode == ecode_ade || wb_ecode == ecode_ale)
                m_badv = (wb_ecode == ecode_ade && wb_esubcode == esubcode_adef) ? wb_pc : wb_vaddr;
        end else begin
            if (ertn_flush) begin
                m_plv = m_pplv;
                m_ie = m_pie;
            end else if (csr_we && csr_num == csr_crmd) begin
                m_plv = nxt[1:0];
                m_ie = nxt[2];
                m_da = nxt[3];
                m_pg = nxt[4];
            end
            if (csr_we && csr_num == csr_prmd) begin
                m_pplv = nxt[1:0];
                m_pie = nxt[2];
            end
            if (csr_we && csr_num == csr_era)
                m_era = nxt;
        end
        if (csr_we && csr_num == csr_eentry)
            m_eentry = nxt & 32'hffff_ffc0;
        if (csr_we && csr_num == csr_ecfg)
            m_lie = nxt[12:0] & ecfg_lie_mask;
        if (csr_we && csr_num == csr_estat)
            m_is_sw = nxt[1:0];
        if (csr_we && csr_num >= csr_save0 && csr_num <= csr_save0 + 14'd3)
            m_save[csr_num[1:0]] = nxt;
        // Expiry beats a clear in the same cycle.
        if (m_cnt == 32'h0)
            m_timer_int = 1'b1;
        else if (ticlr_hit)
            m_timer_int = 1'b0;
        if (tcfg_wr && tcfg_nxt[0])
            m_cnt = tcfg_nxt & 32'hffff_fffc;
        else if (m_tcfg[0] && m_cnt != 32'hffff_ffff)
            m_cnt = (m_cnt == 32'h0 && m_tcfg[1]) ? (m_tcfg & 32'hffff_fffc) : m_cnt - 32'h1;
        if (tcfg_wr)
            m_tcfg = tcfg_nxt;
    end
endtask

`endif

/* testbench/csr_tb.sv */
module csr_tb;
    import csr_pkg::*;

    localparam logic [31:0] core_id    = 32'h0000_0001;
    localparam int          n_random   = 2000;
    localparam int          n_directed = 150;
    localparam int          clk_period = 8;

    logic                  clk;
    logic                  reset;
    logic [csr_num_w-1:0]  csr_num;
    logic                  csr_we;
    logic [csr_data_w-1:0] csr_wmask;
    logic [csr_data_w-1:0] csr_wvalue;
    logic                  wb_ex;
    logic                  ertn_flush;
    logic [csr_data_w-1:0] wb_pc;
    logic [5:0]            wb_ecode;
    logic [8:0]            wb_esubcode;
    logic [csr_data_w-1:0] wb_vaddr;
    logic [7:0]            hw_int_in;
    logic                  ipi_int_in;
    logic [csr_data_w-1:0] csr_rvalue;
    logic                  has_int;
    logic [csr_data_w-1:0] ex_entry;
    logic [csr_data_w-1:0] ertn_entry;
    int                    errors;
    int                    checks;
    bit                    checks_on;
    logic [csr_num_w-1:0]  num_list [18];

    `include "csr_ref_model.svh"

    csr_top #(.CORE_ID(core_id), .SAVE_COUNT(4)) u_csr_top (
        .clk(clk), .reset(reset),
        .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush), .wb_pc(wb_pc),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_vaddr(wb_vaddr),
        .hw_int_in(hw_int_in), .ipi_int_in(ipi_int_in),
        .csr_rvalue(csr_rvalue), .has_int(has_int),
        .ex_entry(ex_entry), .ertn_entry(ertn_entry)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog sized from the directed and random cycle counts.
    initial begin
        #((n_random + n_directed + 200) * clk_period);
        $display("Timeout: the test did not reach its end in time");
        $display("Done: errors found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s expected 0x%08h got 0x%08h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_outputs();
        check_value($sformatf("csr_rvalue[0x%03h]", csr_num), expected_read(csr_num), csr_rvalue);
        check_value("has_int", {31'h0, expected_has_int()}, {31'h0, has_int});
        check_value("ex_entry", m_eentry, ex_entry);
        check_value("ertn_entry", m_era, ertn_entry);
    endtask

    // Inputs change 1 unit after the edge, outputs are sampled mid cycle.
    task automatic finish_cycle();
        @(posedge clk);
        model_update();
        #1;
        csr_we = 1'b0;
        wb_ex = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic tick();
        #2;
        if (checks_on)
            check_outputs();
        finish_cycle();
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] value,
                             input logic [31:0] mask);
        csr_num = num;
        csr_we = 1'b1;
        csr_wvalue = value;
        csr_wmask = mask;
        tick();
    endtask

    task automatic read_masked(input logic [13:0] num, input string name,
                               input logic [31:0] mask, input logic [31:0] exp);
        csr_num = num;
        #2;
        check_outputs();
        check_value(name, exp, csr_rvalue & mask);
        finish_cycle();
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] subcode);
        logic [2:0]  prev;
        logic [31:0] pc;
        logic [31:0] vaddr;
        // Nonzero so that the cleared PLV and IE show.
        prev = 3'($urandom % 7) + 3'd1;
        pc = $urandom;
        vaddr = $urandom;
        write_csr(csr_crmd, {29'h0, prev}, 32'h7);
        wb_ex = 1'b1;
        wb_pc = pc;
        wb_ecode = ecode;
        wb_esubcode = subcode;
        wb_vaddr = vaddr;
        tick();
        read_masked(csr_prmd, "prmd.pplv_pie", 32'h7, {29'h0, prev});
        read_masked(csr_crmd, "crmd.plv_ie", 32'h7, 32'h0);
        read_masked(csr_era, "era", 32'hffff_ffff, pc);
        read_masked(csr_estat, "estat.code", 32'h7fff_0000, {1'b0, subcode, ecode, 16'h0});
        if (ecode == ecode_ade || ecode == ecode_ale)
            read_masked(csr_badv, "badv", 32'hffff_ffff,
                        (ecode == ecode_ade && subcode == esubcode_adef) ? pc : vaddr);
    endtask

    task automatic return_from_exception();
        logic [2:0] saved;
        saved = 3'($urandom % 7) + 3'd1;
        write_csr(csr_prmd, {29'h0, saved}, 32'h7);
        ertn_flush = 1'b1;
        csr_num = csr_era;
        tick();
        read_masked(csr_crmd, "crmd.plv_ie after ertn", 32'h7, {29'h0, saved});
    endtask

    task automatic run_timer_test();
        // Initval 5, one-shot, enabled.
        write_csr(csr_tcfg, 32'h0000_0015, 32'hffff_ffff);
        for (int i = 0; i <= 20; i++)
            read_masked(csr_tval, "tval one-shot", 32'hffff_ffff, 32'(20 - i));
        // The flag rises on the edge after the count reaches zero.
        read_masked(csr_estat, "estat.is timer set", 32'h0000_0800, 32'h0000_0800);
        repeat (3)
            read_masked(csr_tval, "tval stopped", 32'hffff_ffff, 32'hffff_ffff);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        read_masked(csr_estat, "estat.is timer cleared", 32'h0000_0800, 32'h0);
        // Initval 3, periodic, enabled.
        write_csr(csr_tcfg, 32'h0000_000f, 32'hffff_ffff);
        for (int i = 0; i < 30; i++)
            read_masked(csr_tval, "tval periodic", 32'hffff_ffff, 32'(12 - (i % 13)));
        write_csr(csr_tcfg, 32'h0, 32'hffff_ffff);
        write_csr(csr_ticlr, 32'h1, 32'h1);
    endtask

    task automatic run_random();
        logic [31:0] r;
        for (int n = 0; n < n_random; n++) begin
            r = $urandom;
            csr_num = num_list[$urandom % 18];
            csr_we = r[0] && !(csr_num inside {csr_tid, csr_tval, csr_badv});
            csr_wmask = r[1] ? 32'hffff_ffff : $urandom;
            // Small initval so the timer expires now and then.
            csr_wvalue = (csr_num == csr_tcfg) ? ($urandom & 32'h0000_00ff) : $urandom;
            wb_ex = (r[5:2] == 4'h0);
            ertn_flush = !wb_ex && (r[9:6] == 4'h0);
            wb_pc = $urandom;
            wb_vaddr = $urandom;
            wb_ecode = r[10] ? (r[11] ? ecode_ale : ecode_ade) : 6'($urandom);
            wb_esubcode = r[12] ? esubcode_adef : 9'($urandom);
            hw_int_in = 8'($urandom);
            ipi_int_in = r[13];
            tick();
        end
    endtask

    initial begin
        void'($urandom(32'h7b06));
        errors = 0;
        checks = 0;
        checks_on = 1'b0;
        num_list = '{csr_crmd, csr_prmd, csr_ecfg, csr_estat, csr_era, csr_badv, csr_eentry,
                     csr_save0, csr_save0 + 14'd1, csr_save0 + 14'd2, csr_save0 + 14'd3,
                     csr_tid, csr_tcfg, csr_tval, csr_ticlr, 14'h002, 14'h034, 14'h3fff};
        reset = 1'b1;
        csr_num = '0;
        csr_we = 1'b0;
        csr_wmask = '0;
        csr_wvalue = '0;
        wb_ex = 1'b0;
        ertn_flush = 1'b0;
        wb_pc = '0;
        wb_ecode = '0;
        wb_esubcode = '0;
        wb_vaddr = '0;
        hw_int_in = '0;
        ipi_int_in = 1'b0;
        repeat (5) tick();
        reset = 1'b0;

        // Registers without a reset get a known value first.
        write_csr(csr_era, $urandom, 32'hffff_ffff);
        write_csr(csr_eentry, $urandom, 32'hffff_ffff);
        write_csr(csr_prmd, $urandom, 32'hffff_ffff);
        for (int k = 0; k < 4; k++)
            write_csr(csr_save0 + 14'(k), $urandom, 32'hffff_ffff);
        checks_on = 1'b1;

        // PG set, DATF and DATM both 01.
        read_masked(csr_crmd, "crmd after reset", 32'hffff_ffff, 32'h0000_00b0);
        read_masked(csr_tid, "tid", 32'hffff_ffff, core_id);
        read_masked(csr_ecfg, "ecfg after reset", 32'hffff_ffff, 32'h0);
        read_masked(csr_tval, "tval after reset", 32'hffff_ffff, 32'hffff_ffff);
        read_masked(14'h002, "unmapped csr", 32'hffff_ffff, 32'h0);
        read_masked(csr_eentry, "eentry.low", 32'h3f, 32'h0);
        write_csr(csr_ecfg, 32'hffff_ffff, 32'hffff_ffff);
        read_masked(csr_ecfg, "ecfg.lie", 32'hffff_ffff, 32'h0000_1bff);
        write_csr(csr_ecfg, 32'h0, 32'hffff_ffff);

        raise_exception(ecode_ade, esubcode_adef);
        raise_exception(ecode_ade, 9'h001);
        raise_exception(ecode_ale, 9'($urandom));
        raise_exception(6'h0b, 9'h000);
        return_from_exception();
        run_timer_test();
        run_random();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* all.f */
+incdir+testbench
logic/csr_pkg.sv
logic/csr_priv_state.sv
logic/csr_int_ctrl.sv
logic/csr_timer.sv
logic/csr_save_regs.sv
logic/csr_top.sv
testbench/csr_tb.sv

/* run.sh */
#!/bin/sh
# Builds the CSR testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module csr_tb -f all.f -o csr_sim \
    > build.log 2>&1 &&
./obj_dir/csr_sim > run.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and run.log"; exit 1; }
grep -q "Done: no errors" run.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see run.log"; exit 1; }
